// ==== rtl/audio_pkg.sv ====
// Audio sample types, speaker level and compressor curve constants
// Samples are signed two's complement, 16 bits per channel

`default_nettype none

package audio_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sample types

	typedef logic signed [15:0] sample_t;

	// One bit of headroom for the three-source sum
	typedef logic signed [16:0] mix_t;

	// Speaker volume step, each step doubles the amplitude
	typedef logic [1:0] spk_level_t;

	// Compressor curve select, the unused code 3 decodes as hard
	typedef enum logic [1:0] {
		COMP_OFF  = 2'd0,
		COMP_SOFT = 2'd1,
		COMP_HARD = 2'd2
	} comp_mode_e;

	localparam int SAMPLE_MAX = 32767;
	localparam int SAMPLE_MIN = -32768;

	// Speaker amplitude at level 0 is one shifted left by this
	localparam int SPK_BASE_SHIFT = 11;

	////////////////////////////////////////////////////////////////////////////
	// Compressor curves
	// Knee is set so the upper segment lands near full scale

	localparam int COMP_SOFT_GAIN  = 2;
	localparam int COMP_SOFT_SLOPE = 4;
	localparam int COMP_SOFT_KNEE  =
		((SAMPLE_MAX * (COMP_SOFT_SLOPE - 1)) / (COMP_SOFT_SLOPE * COMP_SOFT_GAIN - 1)) + 1;
	localparam int COMP_SOFT_BASE  = COMP_SOFT_KNEE * COMP_SOFT_GAIN;

	localparam int COMP_HARD_GAIN  = 4;
	localparam int COMP_HARD_SLOPE = 8;
	localparam int COMP_HARD_KNEE  =
		((SAMPLE_MAX * (COMP_HARD_SLOPE - 1)) / (COMP_HARD_SLOPE * COMP_HARD_GAIN - 1)) + 1;
	localparam int COMP_HARD_BASE  = COMP_HARD_KNEE * COMP_HARD_GAIN;

endpackage

`default_nettype wire

// ==== rtl/status_pkg.sv ====
// Disk request widths and LED hold time
// Hold default assumes a clock of roughly 90 MHz, about 50 ms of glow

`default_nettype none

package status_pkg;

	// Three request lines per IDE channel, two channels
	typedef logic [5:0] ide_req_t;

	// One request line per floppy drive
	typedef logic [1:0] fdd_req_t;

	// Cycles an activity LED stays lit after the last request
	localparam int LED_HOLD_DEFAULT = 4500000;

endpackage

`default_nettype wire

// ==== rtl/sample_sync.sv ====
// Stereo capture that only passes a sample once it has settled
// Output follows a held input three cycles after it is applied

`default_nettype none

module sample_sync (
	input  wire                clk_sys,
	input  wire                reset,
	input  wire audio_pkg::sample_t in_l,
	input  wire audio_pkg::sample_t in_r,
	output audio_pkg::sample_t out_l,
	output audio_pkg::sample_t out_r
);
	import audio_pkg::*;

	sample_t cap0_l;
	sample_t cap1_l;
	sample_t cap0_r;
	sample_t cap1_r;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cap0_l <= '0;
			cap1_l <= '0;
			cap0_r <= '0;
			cap1_r <= '0;
			out_l  <= '0;
			out_r  <= '0;
		end else begin
			cap0_l <= in_l;
			cap1_l <= cap0_l;
			cap0_r <= in_r;
			cap1_r <= cap0_r;
			// Two equal captures in a row mean the source has settled
			if (cap0_l == cap1_l)
				out_l <= cap1_l;
			if (cap0_r == cap1_r)
				out_r <= cap1_r;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/audio_mixer.sv ====
// Sound card, PC speaker and synth mixer with 16-bit saturation
// Sum path is two cycles, speaker adds one more for its level register

`default_nettype none

module audio_mixer (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire audio_pkg::sample_t    sb_l,
	input  wire audio_pkg::sample_t    sb_r,
	input  wire audio_pkg::sample_t    synth_l,
	input  wire audio_pkg::sample_t    synth_r,
	input  wire                    synth_mute,
	input  wire                    speaker,
	input  wire audio_pkg::spk_level_t spk_level,
	output audio_pkg::sample_t     mix_l,
	output audio_pkg::sample_t     mix_r
);
	import audio_pkg::*;

	mix_t spk_amp;
	mix_t synth_ext_l;
	mix_t synth_ext_r;
	mix_t sum_l;
	mix_t sum_r;

	// Clamp when the two top bits of the sum disagree
	function automatic sample_t saturate(input mix_t sum);
		if (sum[16] ^ sum[15])
			return {sum[16], {15{sum[15]}}};
		else
			return sum[15:0];
	endfunction

	// Muted synth contributes nothing to the sum
	assign synth_ext_l = synth_mute ? '0 : mix_t'(synth_l);
	assign synth_ext_r = synth_mute ? '0 : mix_t'(synth_r);

	////////////////////////////////////////////////////////////////////////////
	// Level, sum and clamp stages

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			spk_amp <= '0;
			sum_l   <= '0;
			sum_r   <= '0;
			mix_l   <= '0;
			mix_r   <= '0;
		end else begin
			spk_amp <= mix_t'(speaker) << (SPK_BASE_SHIFT + spk_level);
			// Wraps modulo 2^17, the clamp stage sorts out the overflow
			sum_l   <= mix_t'(sb_l) + spk_amp + synth_ext_l;
			sum_r   <= mix_t'(sb_r) + spk_amp + synth_ext_r;
			mix_l   <= saturate(sum_l);
			mix_r   <= saturate(sum_r);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/audio_compressor.sv ====
// One channel of the two-curve magnitude compressor, one cycle of latency
// Curve result is clamped to the 16-bit range after the sign is restored

`default_nettype none

module audio_compressor (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire audio_pkg::comp_mode_e mode,
	input  wire audio_pkg::sample_t    in_sample,
	output audio_pkg::sample_t     out_sample
);
	import audio_pkg::*;

	int knee;
	int gain;
	int slope;
	int base;
	int mag;
	int curve;
	int shaped;
	sample_t comp_val;

	// Curve select, code 3 falls through to the hard curve
	always_comb begin
		case (mode)
			COMP_SOFT: begin
				knee  = COMP_SOFT_KNEE;
				gain  = COMP_SOFT_GAIN;
				slope = COMP_SOFT_SLOPE;
				base  = COMP_SOFT_BASE;
			end
			default: begin
				knee  = COMP_HARD_KNEE;
				gain  = COMP_HARD_GAIN;
				slope = COMP_HARD_SLOPE;
				base  = COMP_HARD_BASE;
			end
		endcase
	end

	// Linear gain below the knee, shallow slope above it
	always_comb begin
		mag = in_sample[15] ? -int'(in_sample) : int'(in_sample);
		if (mag < knee)
			curve = mag * gain;
		else
			curve = (mag - knee) / slope + base;
		shaped = in_sample[15] ? -curve : curve;
		if (shaped > SAMPLE_MAX)
			comp_val = sample_t'(SAMPLE_MAX);
		else if (shaped < SAMPLE_MIN)
			comp_val = sample_t'(SAMPLE_MIN);
		else
			comp_val = sample_t'(shaped);
	end

	// Bypass goes through the same register so both modes line up
	always_ff @(posedge clk_sys) begin
		if (reset)
			out_sample <= '0;
		else if (mode == COMP_OFF)
			out_sample <= in_sample;
		else
			out_sample <= comp_val;
	end

endmodule

`default_nettype wire

// ==== rtl/activity_led.sv ====
// Stretches short request pulses into a visible LED glow
// LED lights one cycle after a request, goes dark HOLD_CYCLES after the last

`default_nettype none

module activity_led #(
	parameter int HOLD_CYCLES = status_pkg::LED_HOLD_DEFAULT
) (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  request,
	output logic led
);
	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= '0;
			led   <= 1'b0;
		end else begin
			if (count != '0) begin
				led   <= 1'b1;
				count <= count - 1'b1;
			end else begin
				led <= 1'b0;
			end
			// A new request restarts the hold time
			if (request)
				count <= CNT_W'(HOLD_CYCLES);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pc_audio_top.sv ====
// Audio output path and disk activity LEDs, all on clk_sys
// Sound card 6 cycles to output, speaker 4, synth 3, comp_mode 1

`default_nettype none

module pc_audio_top #(
	parameter int LED_HOLD = status_pkg::LED_HOLD_DEFAULT
) (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire audio_pkg::sample_t    sb_l,
	input  wire audio_pkg::sample_t    sb_r,
	input  wire audio_pkg::sample_t    mt32_l,
	input  wire audio_pkg::sample_t    mt32_r,
	input  wire                    mt32_mute,
	input  wire                    speaker,
	input  wire audio_pkg::spk_level_t spk_level,
	input  wire audio_pkg::comp_mode_e comp_mode,
	input  wire status_pkg::ide_req_t  ide_req,
	input  wire status_pkg::fdd_req_t  fdd_req,
	output audio_pkg::sample_t     audio_l,
	output audio_pkg::sample_t     audio_r,
	output logic                   led_hdd,
	output logic                   led_fdd
);
	import audio_pkg::*;

	sample_t sync_l;
	sample_t sync_r;
	sample_t mix_l;
	sample_t mix_r;

	////////////////////////////////////////////////////////////////////////////
	// Audio chain

	sample_sync sb_sync_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.in_l    (sb_l),
		.in_r    (sb_r),
		.out_l   (sync_l),
		.out_r   (sync_r)
	);

	audio_mixer mixer_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sb_l       (sync_l),
		.sb_r       (sync_r),
		.synth_l    (mt32_l),
		.synth_r    (mt32_r),
		.synth_mute (mt32_mute),
		.speaker    (speaker),
		.spk_level  (spk_level),
		.mix_l      (mix_l),
		.mix_r      (mix_r)
	);

	audio_compressor comp_l_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mode       (comp_mode),
		.in_sample  (mix_l),
		.out_sample (audio_l)
	);

	audio_compressor comp_r_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mode       (comp_mode),
		.in_sample  (mix_r),
		.out_sample (audio_r)
	);

	////////////////////////////////////////////////////////////////////////////
	// Activity LEDs, any request line of a device lights its LED

	activity_led #(.HOLD_CYCLES(LED_HOLD)) hdd_led_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.request (|ide_req),
		.led     (led_hdd)
	);

	activity_led #(.HOLD_CYCLES(LED_HOLD)) fdd_led_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.request (|fdd_req),
		.led     (led_fdd)
	);

endmodule

`default_nettype wire

// ==== verif/pc_audio_props.sv ====
// Reset state and LED response assertions, bound into pc_audio_top
// LED properties are off while reset is high

`default_nettype none

module pc_audio_props (
	input wire                     clk_sys,
	input wire                     reset,
	input wire status_pkg::ide_req_t ide_req,
	input wire status_pkg::fdd_req_t fdd_req,
	input wire audio_pkg::sample_t   audio_l,
	input wire audio_pkg::sample_t   audio_r,
	input wire                     led_hdd,
	input wire                     led_fdd
);

	// Every output is cleared the cycle after a reset edge
	property reset_clears_outputs;
		@(posedge clk_sys) reset |=> (audio_l == '0 && audio_r == '0 && !led_hdd && !led_fdd);
	endproperty

	property hdd_request_lights;
		@(posedge clk_sys) disable iff (reset) (|ide_req) |-> ##2 led_hdd;
	endproperty

	property fdd_request_lights;
		@(posedge clk_sys) disable iff (reset) (|fdd_req) |-> ##2 led_fdd;
	endproperty

	assert property (reset_clears_outputs) else $error("Outputs not cleared after reset");
	assert property (hdd_request_lights) else $error("led_hdd not lit after ide_req");
	assert property (fdd_request_lights) else $error("led_fdd not lit after fdd_req");

endmodule

bind pc_audio_top pc_audio_props pc_audio_props_i (
	.clk_sys (clk_sys),
	.reset   (reset),
	.ide_req (ide_req),
	.fdd_req (fdd_req),
	.audio_l (audio_l),
	.audio_r (audio_r),
	.led_hdd (led_hdd),
	.led_fdd (led_fdd)
);

`default_nettype wire

// ==== verif/pc_audio_tb.sv ====
// Testbench for pc_audio_top with an LED hold time of 20 cycles
// Expected audio comes from a behavioral model of the mixer and compressor

`default_nettype none

module pc_audio_tb;
	import audio_pkg::*;
	import status_pkg::*;

	localparam int HOLD = 20;
	localparam int SETTLE = 10;
	localparam int SPK_SHIFT = 11;

	typedef struct packed {
		sample_t    sb_l;
		sample_t    sb_r;
		sample_t    mt_l;
		sample_t    mt_r;
		logic       mute;
		logic       spk;
		spk_level_t lvl;
		comp_mode_e mode;
		sample_t    exp_l;
		sample_t    exp_r;
	} row_t;

	logic       clk_sys = 1'b0;
	logic       reset;
	sample_t    sb_l;
	sample_t    sb_r;
	sample_t    mt32_l;
	sample_t    mt32_r;
	logic       mt32_mute;
	logic       speaker;
	spk_level_t spk_level;
	comp_mode_e comp_mode;
	ide_req_t   ide_req;
	fdd_req_t   fdd_req;
	sample_t    audio_l;
	sample_t    audio_r;
	logic       led_hdd;
	logic       led_fdd;

	row_t  rows[$];
	string names[$];
	int    seed = 44398;

	always #4 clk_sys = ~clk_sys;

	pc_audio_top #(.LED_HOLD(HOLD)) pc_audio_top_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.sb_l      (sb_l),
		.sb_r      (sb_r),
		.mt32_l    (mt32_l),
		.mt32_r    (mt32_r),
		.mt32_mute (mt32_mute),
		.speaker   (speaker),
		.spk_level (spk_level),
		.comp_mode (comp_mode),
		.ide_req   (ide_req),
		.fdd_req   (fdd_req),
		.audio_l   (audio_l),
		.audio_r   (audio_r),
		.led_hdd   (led_hdd),
		.led_fdd   (led_fdd)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic int clamp16(input int value);
		if (value > 32767)
			return 32767;
		if (value < -32768)
			return -32768;
		return value;
	endfunction

	function automatic sample_t model_output(input sample_t sb, input sample_t synth,
			input logic mute, input logic spk, input spk_level_t lvl, input comp_mode_e mode);
		int sum;
		int mag;
		int curve;
		int knee;
		int gain;
		int slope;
		int base;
		sum = int'(sb);
		if (!mute)
			sum += int'(synth);
		if (spk)
			sum += 1 << (SPK_SHIFT + int'(lvl));
		// Mixer keeps 17 bits, so the sum wraps before the clamp
		sum = sum & 'h1FFFF;
		if (sum > 'hFFFF)
			sum -= 'h20000;
		sum = clamp16(sum);
		if (mode == COMP_OFF)
			return sample_t'(sum);
		// Soft curve for mode 1, hard curve for 2 and 3
		if (mode == COMP_SOFT) begin
			knee  = 14044;
			gain  = 2;
			slope = 4;
			base  = 28088;
		end else begin
			knee  = 7400;
			gain  = 4;
			slope = 8;
			base  = 29600;
		end
		mag = (sum < 0) ? -sum : sum;
		curve = (mag < knee) ? mag * gain : (mag - knee) / slope + base;
		return sample_t'(clamp16((sum < 0) ? -curve : curve));
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks and waits

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
		if (actual !== expected) begin
			$display("FAIL %s expected %0d actual %0d", name, expected, actual);
			abort_run("Audio output does not match the model");
		end
	endtask

	task automatic check_led(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAIL %s expected %b actual %b", name, expected, actual);
			abort_run("LED output does not match the expected state");
		end
	endtask

	task automatic wait_led(input string name, input bit use_fdd, input logic level,
			input int limit);
		int cycles;
		cycles = 0;
		while ((use_fdd ? led_fdd : led_hdd) !== level) begin
			if (cycles >= limit)
				abort_run($sformatf("Timeout in %s: LED did not turn %s within %0d cycles",
					name, level ? "on" : "off", limit));
			@(negedge clk_sys);
			cycles++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic add_row(input string name, input int l, input int r, input int ml,
			input int mr, input logic mute, input logic spk, input int lvl, input comp_mode_e mode);
		row_t row;
		row.sb_l  = sample_t'(l);
		row.sb_r  = sample_t'(r);
		row.mt_l  = sample_t'(ml);
		row.mt_r  = sample_t'(mr);
		row.mute  = mute;
		row.spk   = spk;
		row.lvl   = spk_level_t'(lvl);
		row.mode  = mode;
		row.exp_l = model_output(row.sb_l, row.mt_l, mute, spk, row.lvl, mode);
		row.exp_r = model_output(row.sb_r, row.mt_r, mute, spk, row.lvl, mode);
		rows.push_back(row);
		names.push_back(name);
	endtask

	// Same magnitude on both channels with opposite signs
	task automatic add_comp_row(input string name, input int value, input comp_mode_e mode);
		add_row(name, value, -value, 0, 0, 1'b1, 1'b0, 0, mode);
	endtask

	task automatic apply_row(input string name, input row_t row);
		@(negedge clk_sys);
		sb_l      = row.sb_l;
		sb_r      = row.sb_r;
		mt32_l    = row.mt_l;
		mt32_r    = row.mt_r;
		mt32_mute = row.mute;
		speaker   = row.spk;
		spk_level = row.lvl;
		comp_mode = row.mode;
		repeat (SETTLE) @(negedge clk_sys);
		check_sample({name, " left"}, row.exp_l, audio_l);
		check_sample({name, " right"}, row.exp_r, audio_r);
	endtask

	task automatic run_stability_test();
		sample_t held;
		int i;
		held = 16'sd1234;
		@(negedge clk_sys);
		sb_l      = held;
		sb_r      = -held;
		mt32_mute = 1'b1;
		speaker   = 1'b0;
		comp_mode = COMP_OFF;
		repeat (SETTLE) @(negedge clk_sys);
		// A source that never settles must not reach the mixer
		for (i = 0; i < 12; i++) begin
			sb_l = held + sample_t'(100 + i * 37);
			sb_r = held - sample_t'(300 + i * 53);
			@(negedge clk_sys);
			check_sample("unstable left", held, audio_l);
			check_sample("unstable right", -held, audio_r);
		end
	endtask

	task automatic run_led_test(input string name, input bit use_fdd);
		@(negedge clk_sys);
		if (use_fdd)
			fdd_req = 2'b10;
		else
			ide_req = 6'b001000;
		@(negedge clk_sys);
		ide_req = '0;
		fdd_req = '0;
		wait_led({name, " rise"}, use_fdd, 1'b1, 1);
		// First lit cycle already seen
		repeat (HOLD - 1) begin
			@(negedge clk_sys);
			check_led({name, " lit"}, 1'b1, use_fdd ? led_fdd : led_hdd);
			check_led({name, " other"}, 1'b0, use_fdd ? led_hdd : led_fdd);
		end
		wait_led({name, " fall"}, use_fdd, 1'b0, 1);
	endtask

	initial begin
		int lvl;
		reset     = 1'b1;
		sb_l      = '0;
		sb_r      = '0;
		mt32_l    = '0;
		mt32_r    = '0;
		mt32_mute = 1'b0;
		speaker   = 1'b0;
		spk_level = '0;
		comp_mode = COMP_OFF;
		ide_req   = '0;
		fdd_req   = '0;
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;
		check_sample("reset left", 16'sd0, audio_l);
		check_sample("reset right", 16'sd0, audio_r);
		check_led("reset hdd", 1'b0, led_hdd);
		check_led("reset fdd", 1'b0, led_fdd);

		for (lvl = 0; lvl < 4; lvl++) begin
			add_row($sformatf("mix level %0d", lvl), $random(seed) % 12000,
				$random(seed) % 12000, $random(seed) % 12000, $random(seed) % 12000,
				1'b0, 1'b1, lvl, COMP_OFF);
			add_row($sformatf("mix muted level %0d", lvl), $random(seed) % 12000,
				$random(seed) % 12000, $random(seed) % 12000, $random(seed) % 12000,
				1'b1, 1'b1, lvl, COMP_OFF);
		end
		add_row("sat positive", 20000, 30000, 20000, 5000, 1'b0, 1'b0, 0, COMP_OFF);
		add_row("sat negative", -20000, -30000, -20000, -5000, 1'b0, 1'b0, 0, COMP_OFF);
		add_row("sum wrap", 32767, 32767, 32767, 32767, 1'b0, 1'b1, 3, COMP_OFF);
		add_comp_row("soft small", 100, COMP_SOFT);
		add_comp_row("soft mid", 10000, COMP_SOFT);
		add_comp_row("soft below knee", 14043, COMP_SOFT);
		add_comp_row("soft knee", 14044, COMP_SOFT);
		add_comp_row("soft full", 32767, COMP_SOFT);
		add_comp_row("hard small", 1000, COMP_HARD);
		add_comp_row("hard knee", 7400, COMP_HARD);
		add_comp_row("hard mid", 20000, COMP_HARD);
		add_comp_row("hard full", 32767, COMP_HARD);
		add_comp_row("hard negative full", -32768, COMP_HARD);
		add_comp_row("mode 3", 5000, comp_mode_e'(2'd3));

		foreach (rows[i])
			apply_row(names[i], rows[i]);
		run_stability_test();
		run_led_test("hdd", 1'b0);
		run_led_test("fdd", 1'b1);

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/audio_pkg.sv
rtl/status_pkg.sv
rtl/sample_sync.sv
rtl/audio_mixer.sv
rtl/audio_compressor.sv
rtl/activity_led.sv
rtl/pc_audio_top.sv
verif/pc_audio_props.sv
verif/pc_audio_tb.sv

// ==== Makefile ====
# Verilator build and run of the pc_audio testbench

VERILATOR ?= verilator
TOP       ?= pc_audio_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails if an error is reported"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
